// ==== hw/riscv_m_pkg.sv ====
package riscv_m_pkg;

    // integer register width of the RV64 base ISA.
    localparam int xlen = 64;

    // funct3 of the M-extension divide group.
    // the same encodings serve the OP and OP-32 forms; the word
    // forms are told apart by the opcode, which arrives here as word.
    localparam logic [2:0] funct3_div  = 3'b100;
    localparam logic [2:0] funct3_divu = 3'b101;
    localparam logic [2:0] funct3_rem  = 3'b110;
    localparam logic [2:0] funct3_remu = 3'b111;

endpackage

// ==== hw/div_pkg.sv ====
package div_pkg;

    // sequencer of the iterative divider.
    // idle waits for start, run covers the setup cycle and the
    // shift-subtract steps, fin presents the result for one cycle.
    typedef enum logic [1:0] {
        idle = 2'd0,
        run  = 2'd1,
        fin  = 2'd2
    } div_state_e;

    // iteration counter, wide enough for setup plus 64 steps.
    localparam int cnt_w = 7;

endpackage

// ==== hw/div_operand_prep.sv ====
`timescale 1ns/1ps

module div_operand_prep #(
    parameter int width = 64
) (
    input  logic [2:0]       funct3,
    input  logic             word,
    input  logic [width-1:0] rs1,
    input  logic [width-1:0] rs2,
    output logic [width-1:0] dividend_mag,
    output logic [width-1:0] divisor_mag,
    output logic             neg_quot,
    output logic             neg_rem
);
    import riscv_m_pkg::*;

    // selects the low 32 bits of a register.
    localparam logic [width-1:0] lo_mask = width'(32'hffff_ffff);

    logic             is_signed;
    logic [width-1:0] a_fill;
    logic [width-1:0] b_fill;
    logic [width-1:0] a_ext;
    logic [width-1:0] b_ext;
    logic             a_neg;
    logic             b_neg;
    logic             b_zero;

    assign is_signed = (funct3 == funct3_div) || (funct3 == funct3_rem);

    // word forms keep the low half and refill the rest by signedness.
    assign a_fill = {width{is_signed & rs1[31]}};
    assign b_fill = {width{is_signed & rs2[31]}};

    always_comb begin
        if (word) begin
            a_ext = (rs1 & lo_mask) | (a_fill & ~lo_mask);
            b_ext = (rs2 & lo_mask) | (b_fill & ~lo_mask);
        end else begin
            a_ext = rs1;
            b_ext = rs2;
        end
    end

    assign a_neg  = is_signed & a_ext[width-1];
    assign b_neg  = is_signed & b_ext[width-1];
    assign b_zero = (b_ext == '0);

    // the most negative value maps onto itself, read as unsigned it is
    // already the right magnitude.
    assign dividend_mag = a_neg ? -a_ext : a_ext;
    assign divisor_mag  = b_neg ? -b_ext : b_ext;

    // remainder follows the dividend.
    assign neg_rem = a_neg;

    // a zero divisor must leave the all-ones quotient unnegated.
    assign neg_quot = (a_neg ^ b_neg) & ~b_zero;

endmodule

// ==== hw/div_core.sv ====
`timescale 1ns/1ps

module div_core #(
    parameter int width = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [width-1:0] dividend_mag,
    input  logic [width-1:0] divisor_mag,
    input  logic             neg_quot,
    input  logic             neg_rem,
    input  logic [2:0]       funct3,
    input  logic             word,
    output logic             busy,
    output logic             done,
    output logic [width-1:0] quot,
    output logic [width-1:0] rem,
    output logic             neg_quot_q,
    output logic             neg_rem_q,
    output logic [2:0]       funct3_q,
    output logic             word_q
);
    import div_pkg::*;

    div_state_e         state;
    logic [cnt_w-1:0]   cnt;
    logic [width-1:0]   dividend_q;
    logic [width-1:0]   divisor_q;
    logic [2*width-1:0] part;
    logic [width:0]     shift_hi;
    logic [width-1:0]   diff;
    logic               ge;
    logic               accept;

    // busy and done low together means the sequencer is idle.
    assign accept = start && (state == idle);

    // upper half after the shift, one bit wider than the divisor.
    assign shift_hi = part[2*width-1:width-1];
    assign ge       = shift_hi >= {1'b0, divisor_q};
    assign diff     = shift_hi[width-1:0] - divisor_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= run;
                        cnt   <= '0;
                    end
                end
                run: begin
                    cnt <= cnt + 1'b1;
                    // step count 0 is setup, steps 1 to width shift.
                    if (cnt == cnt_w'(width)) begin
                        state <= fin;
                    end
                end
                fin: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // operands and flags stay put from accept until the next accept.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dividend_q <= '0;
            divisor_q  <= '0;
            neg_quot_q <= 1'b0;
            neg_rem_q  <= 1'b0;
            funct3_q   <= 3'b000;
            word_q     <= 1'b0;
        end else if (accept) begin
            dividend_q <= dividend_mag;
            divisor_q  <= divisor_mag;
            neg_quot_q <= neg_quot;
            neg_rem_q  <= neg_rem;
            funct3_q   <= funct3;
            word_q     <= word;
        end
    end

    // restoring shift-subtract, upper half remainder, lower half quotient.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            part <= '0;
        end else if (state == run) begin
            if (cnt == '0) begin
                part <= {{width{1'b0}}, dividend_q};
            end else if (ge) begin
                part <= {diff, part[width-2:0], 1'b1};
            end else begin
                part <= {part[2*width-2:0], 1'b0};
            end
        end
    end

    assign busy = (state == run);
    assign done = (state == fin);
    assign quot = part[width-1:0];
    assign rem  = part[2*width-1:width];

endmodule

// ==== hw/div_result_sel.sv ====
`timescale 1ns/1ps

module div_result_sel #(
    parameter int width = 64
) (
    input  logic [width-1:0] quot,
    input  logic [width-1:0] rem,
    input  logic             neg_quot,
    input  logic             neg_rem,
    input  logic [2:0]       funct3,
    input  logic             word,
    output logic [width-1:0] result
);
    import riscv_m_pkg::*;

    localparam logic [width-1:0] lo_mask = width'(32'hffff_ffff);

    logic [width-1:0] quot_s;
    logic [width-1:0] rem_s;
    logic [width-1:0] sel;
    logic             is_rem;

    // signs were settled during operand preparation.
    assign quot_s = neg_quot ? -quot : quot;
    assign rem_s  = neg_rem ? -rem : rem;

    assign is_rem = (funct3 == funct3_rem) || (funct3 == funct3_remu);
    assign sel    = is_rem ? rem_s : quot_s;

    // word results are sign-extended from bit 31, signed or not.
    always_comb begin
        if (word) begin
            result = (sel & lo_mask) | ({width{sel[31]}} & ~lo_mask);
        end else begin
            result = sel;
        end
    end

endmodule

// ==== hw/div_unit.sv ====
`timescale 1ns/1ps

module div_unit #(
    parameter int width = riscv_m_pkg::xlen
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [2:0]       funct3,
    input  logic             word,
    input  logic [width-1:0] rs1,
    input  logic [width-1:0] rs2,
    output logic             busy,
    output logic             done,
    output logic [width-1:0] result
);

    logic [width-1:0] dividend_mag;
    logic [width-1:0] divisor_mag;
    logic             neg_quot;
    logic             neg_rem;
    logic [width-1:0] quot;
    logic [width-1:0] rem;
    logic             neg_quot_q;
    logic             neg_rem_q;
    logic [2:0]       funct3_q;
    logic             word_q;

    div_operand_prep #(
        .width(width)
    ) prep_i (
        .funct3      (funct3),
        .word        (word),
        .rs1         (rs1),
        .rs2         (rs2),
        .dividend_mag(dividend_mag),
        .divisor_mag (divisor_mag),
        .neg_quot    (neg_quot),
        .neg_rem     (neg_rem)
    );

    // one quotient bit per cycle.
    div_core #(
        .width(width)
    ) core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .dividend_mag(dividend_mag),
        .divisor_mag (divisor_mag),
        .neg_quot    (neg_quot),
        .neg_rem     (neg_rem),
        .funct3      (funct3),
        .word        (word),
        .busy        (busy),
        .done        (done),
        .quot        (quot),
        .rem         (rem),
        .neg_quot_q  (neg_quot_q),
        .neg_rem_q   (neg_rem_q),
        .funct3_q    (funct3_q),
        .word_q      (word_q)
    );

    div_result_sel #(
        .width(width)
    ) sel_i (
        .quot    (quot),
        .rem     (rem),
        .neg_quot(neg_quot_q),
        .neg_rem (neg_rem_q),
        .funct3  (funct3_q),
        .word    (word_q),
        .result  (result)
    );

endmodule

// ==== tests/div_unit_assert.sv ====
`timescale 1ns/1ps

module div_unit_assert_chk (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        start,
    input logic [2:0]                  funct3,
    input logic                        word,
    input logic [riscv_m_pkg::xlen-1:0] rs1,
    input logic [riscv_m_pkg::xlen-1:0] rs2,
    input logic                        busy,
    input logic                        done,
    input logic [riscv_m_pkg::xlen-1:0] result
);
    import riscv_m_pkg::*;

    // accepting edge to the edge that sees done.
    localparam int latency = xlen + 2;

    int              err_cnt = 0;
    int              ops_cnt;
    logic            accept;
    logic            seen_start;
    logic            in_flight;
    int              cyc;
    logic            exp_word;
    logic [xlen-1:0] exp_result;
    logic            held_valid;
    logic [xlen-1:0] held_val;

    // ISA divide rules, the word forms on 32-bit operands.
    function automatic logic [63:0] ref_result(input logic [2:0] f3, input logic w,
                                               input logic [63:0] a, input logic [63:0] b);
        logic        is_rem;
        logic        is_sgn;
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] r32;
        logic [63:0] r64;
        is_rem = (f3 == funct3_rem) || (f3 == funct3_remu);
        is_sgn = (f3 == funct3_div) || (f3 == funct3_rem);
        a32 = a[31:0];
        b32 = b[31:0];
        if (w) begin
            if (b32 == '0)
                r32 = is_rem ? a32 : '1;
            else if (is_sgn && a32 == 32'h8000_0000 && b32 == '1)
                r32 = is_rem ? '0 : a32;
            else if (is_sgn)
                r32 = is_rem ? 32'($signed(a32) % $signed(b32)) : 32'($signed(a32) / $signed(b32));
            else
                r32 = is_rem ? a32 % b32 : a32 / b32;
            return {{32{r32[31]}}, r32};
        end
        if (b == '0)
            r64 = is_rem ? a : '1;
        else if (is_sgn && a == 64'h8000_0000_0000_0000 && b == '1)
            r64 = is_rem ? '0 : a;
        else if (is_sgn)
            r64 = is_rem ? 64'($signed(a) % $signed(b)) : 64'($signed(a) / $signed(b));
        else
            r64 = is_rem ? a % b : a / b;
        return r64;
    endfunction

    assign accept = start && !busy && !done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_start <= 1'b0;
            in_flight  <= 1'b0;
            cyc        <= 0;
            exp_word   <= 1'b0;
            exp_result <= '0;
            held_valid <= 1'b0;
            held_val   <= '0;
            ops_cnt    <= 0;
        end else begin
            if (accept) begin
                seen_start <= 1'b1;
                in_flight  <= 1'b1;
                cyc        <= 1;
                exp_word   <= word;
                exp_result <= ref_result(funct3, word, rs1, rs2);
                held_valid <= 1'b0;
            end else if (in_flight) begin
                cyc <= cyc + 1;
            end
            if (done) begin
                in_flight  <= 1'b0;
                held_valid <= 1'b1;
                held_val   <= result;
                ops_cnt    <= ops_cnt + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_start |-> !busy && !done && result == '0)
        else begin
            err_cnt++;
            $error("error t=%0t result exp=0 got=%h (busy=%0b done=%0b)", $time, result,
                   busy, done);
        end

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> in_flight && cyc == latency)
        else begin
            err_cnt++;
            $error("error t=%0t done exp_cycle=%0d got_cycle=%0d", $time, latency, cyc);
        end

    // busy covers exactly the cycles between accept and done.
    a_busy_span: assert property (@(posedge clk) disable iff (!rst_n)
        busy == (in_flight && cyc < latency))
        else begin
            err_cnt++;
            $error("error t=%0t busy exp=%0b got=%0b", $time, in_flight && cyc < latency, busy);
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        done && !exp_word |-> result == exp_result)
        else begin
            err_cnt++;
            $error("error t=%0t result exp=%h got=%h", $time, exp_result, result);
        end

    a_result_word: assert property (@(posedge clk) disable iff (!rst_n)
        done && exp_word |-> result == exp_result)
        else begin
            err_cnt++;
            $error("error t=%0t result(word) exp=%h got=%h", $time, exp_result, result);
        end

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        held_valid |-> result == held_val)
        else begin
            err_cnt++;
            $error("error t=%0t result(hold) exp=%h got=%h", $time, held_val, result);
        end

endmodule

bind div_unit div_unit_assert_chk chk_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .funct3(funct3),
    .word  (word),
    .rs1   (rs1),
    .rs2   (rs2),
    .busy  (busy),
    .done  (done),
    .result(result)
);

// ==== tests/tb_div_unit.sv ====
`timescale 1ns/1ps

module tb_div_unit;
    import riscv_m_pkg::*;

    localparam int n_corner    = 8;
    localparam int n_random    = 200;
    localparam int n_ops       = n_corner * 8 + n_random;
    localparam int cycle_limit = n_ops * 70 + 200;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic [2:0]        funct3;
    logic              word;
    logic [xlen-1:0]   rs1;
    logic [xlen-1:0]   rs2;
    logic              busy;
    logic              done;
    logic [xlen-1:0]   result;

    logic [15:0]       lfsr;
    logic [2*xlen-1:0] corners [n_corner];
    logic [2:0]        op_codes [4] = '{funct3_div, funct3_divu, funct3_rem, funct3_remu};
    int                cycles = 0;
    int                issued = 0;

    div_unit #(
        .width(64)
    ) div_unit_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .funct3(funct3),
        .word  (word),
        .rs1   (rs1),
        .rs2   (rs2),
        .busy  (busy),
        .done  (done),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken.
    task automatic take_bits(input int n, output logic [xlen-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[xlen-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic run_op(input logic [2:0] f3, input logic w, input logic [xlen-1:0] a,
                          input logic [xlen-1:0] b, input logic keep_start, input logic gap);
        start  = 1'b1;
        funct3 = f3;
        word   = w;
        rs1    = a;
        rs2    = b;
        @(posedge clk);
        #2;
        // a request held during busy carries other operands.
        start  = keep_start;
        funct3 = f3 ^ 3'b011;
        word   = ~w;
        rs1    = ~a;
        rs2    = b + 1;
        while (!done) begin
            @(posedge clk);
            #2;
        end
        start  = 1'b0;
        issued = issued + 1;
        repeat (gap + 1) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        rst_n  = 1'b0;
        start  = 1'b0;
        funct3 = funct3_div;
        word   = 1'b0;
        rs1    = '0;
        rs2    = '0;
        lfsr   = 16'd20155;
        corners[0] = {64'd123, 64'd0};
        corners[1] = {-64'sd7, 64'd0};
        corners[2] = {64'h8000_0000_0000_0000, {64{1'b1}}};
        corners[3] = {64'h0000_0000_8000_0000, 64'h0000_0000_ffff_ffff};
        corners[4] = {64'd0, 64'd9};
        corners[5] = {64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef};
        corners[6] = {-64'sd100, 64'd7};
        corners[7] = {64'd100, -64'sd7};
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #2;
        end
        for (int c = 0; c < n_corner; c++) begin
            for (int k = 0; k < 8; k++) begin
                run_op(op_codes[k % 4], k >= 4, corners[c][2*xlen-1:xlen],
                       corners[c][xlen-1:0], (c % 2) == 1, 1'b0);
            end
        end
        // low bits of r pick the divisor shift, then op, word, held start, gap.
        for (int i = 0; i < n_random; i++) begin
            take_bits(xlen, a);
            take_bits(xlen, b);
            take_bits(11, r);
            b = b >> r[5:0];
            run_op(op_codes[r[7:6]], r[8], a, b, r[9], r[10]);
        end
        if (div_unit_i.chk_i.ops_cnt != issued) begin
            $display("checker saw %0d completed operations, %0d were issued",
                     div_unit_i.chk_i.ops_cnt, issued);
        end
        $display("operations checked %0d, errors %0d", div_unit_i.chk_i.ops_cnt,
                 div_unit_i.chk_i.err_cnt);
        if (div_unit_i.chk_i.err_cnt == 0 && div_unit_i.chk_i.ops_cnt == issued) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/riscv_m_pkg.sv
hw/div_pkg.sv
hw/div_operand_prep.sv
hw/div_core.sv
hw/div_result_sel.sv
hw/div_unit.sv
tests/div_unit_assert.sv
tests/tb_div_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the divide unit testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_div_unit \
    -f build.f --Mdir obj_dir -o tb_div_unit
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_div_unit +verilator+error+limit+100000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
